//--- rtl/tile_pkg.sv
//////////////////////////////////////////////////////////////////////
// Tile-local types: scratchpad address and data words, the core
// request and response strobes
//////////////////////////////////////////////////////////////////////

package tile_pkg;

  // Scratchpad word address and data word
  typedef logic [7:0]  spm_addr_t;
  typedef logic [31:0] spm_data_t;

  // Mesh coordinate {x, y} as the core sees it, x in the upper two bits
  typedef logic [3:0] core_coord_t;
  // Transaction tag returned with a response
  typedef logic [3:0] core_tag_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    core_coord_t dst;
    spm_addr_t   addr;
    spm_data_t   wdata;
  } core_req_t;

  typedef struct packed {
    logic        valid;
    core_tag_t   tag;
    core_coord_t src;
    spm_data_t   rdata;
  } core_rsp_t;

endpackage

//--- rtl/noc_pkg.sv
//////////////////////////////////////////////////////////////////////
// Mesh network types: tile coordinate, port directions, flit kinds,
// the single-flit packet and the XY routing rule
//////////////////////////////////////////////////////////////////////

package noc_pkg;

  typedef struct packed {
    logic [1:0] x;
    logic [1:0] y;
  } coord_t;

  // Router ports, the four mesh links first
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } dir_e;

  localparam int unsigned NumPorts = 5;

  typedef enum logic [1:0] {
    KindRead  = 2'd0,
    KindWrite = 2'd1,
    KindRsp   = 2'd2
  } flit_kind_e;

  typedef logic [3:0] tag_t;

  typedef struct packed {
    logic                valid;
    coord_t              dst;
    coord_t              src;
    flit_kind_e          kind;
    tag_t                tag;
    tile_pkg::spm_addr_t addr;
    tile_pkg::spm_data_t data;
  } noc_flit_t;

  // Dimension order, X resolved before Y
  function automatic dir_e xy_route(coord_t own, coord_t dst);
    if (dst.x > own.x) return East;
    if (dst.x < own.x) return West;
    if (dst.y > own.y) return South;
    if (dst.y < own.y) return North;
    return Eject;
  endfunction

endpackage

//--- rtl/noc_in_fifo.sv
//////////////////////////////////////////////////////////////////////
// Flit FIFO with first-word fall-through and a sticky overflow flag
//////////////////////////////////////////////////////////////////////

module noc_in_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               push_i,
  input  noc_pkg::noc_flit_t flit_i,
  input  logic               pop_i,
  output noc_pkg::noc_flit_t flit_o,
  output logic               overflow_o
);
  import noc_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [PtrW:0]   cnt_t;

  noc_flit_t mem_q [Depth];
  ptr_t      wr_ptr_q, rd_ptr_q;
  cnt_t      count_q;
  logic      overflow_q;
  logic      empty, full, do_push, do_pop;

  function automatic ptr_t next_ptr(ptr_t ptr);
    return (ptr == ptr_t'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty   = (count_q == '0);
  assign full    = (count_q == cnt_t'(Depth));
  assign do_pop  = pop_i && !empty;
  // A full buffer still takes a flit when its head leaves in the same cycle
  assign do_push = push_i && (!full || do_pop);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (do_push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (do_pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (do_push != do_pop) count_q <= do_push ? count_q + 1'b1 : count_q - 1'b1;
      if (push_i && !do_push) overflow_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= flit_i;
  end

  always_comb begin
    flit_o       = mem_q[rd_ptr_q];
    flit_o.valid = !empty;
  end

  assign overflow_o = overflow_q;

endmodule

//--- rtl/noc_router.sv
//////////////////////////////////////////////////////////////////////
// Five-port XY router: input FIFOs, round-robin arbiter per output,
// registered output links
//////////////////////////////////////////////////////////////////////

module noc_router #(
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  noc_pkg::coord_t                          id_i,
  input  noc_pkg::noc_flit_t [noc_pkg::NumPorts-1:0] flit_i,
  output noc_pkg::noc_flit_t [noc_pkg::NumPorts-1:0] flit_o,
  output logic                                     overflow_o
);
  import noc_pkg::*;

  typedef logic [NumPorts-1:0]         port_mask_t;
  typedef logic [$clog2(NumPorts)-1:0] port_idx_t;

  noc_flit_t  [NumPorts-1:0] head;
  dir_e                      route [NumPorts];
  logic       [NumPorts-1:0] pop, fifo_ovf;
  port_mask_t [NumPorts-1:0] req, gnt;
  port_idx_t  [NumPorts-1:0] gnt_idx, rr_q;
  logic       [NumPorts-1:0] found;
  noc_flit_t  [NumPorts-1:0] out_q;
  logic       [NumPorts-1:0] out_valid_q;

  function automatic port_idx_t rr_index(port_idx_t base, int unsigned off);
    int unsigned sum;
    sum = int'(base) + off;
    return port_idx_t'(sum % NumPorts);
  endfunction

  /////////////////////////////////////////////////////////////////////
  // Input buffers and route computation
  /////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NumPorts; p++) begin : gen_in
    noc_in_fifo #(
      .Depth(InFifoDepth)
    ) i_fifo (
      .clk_i,
      .arst_n_i,
      .push_i    (flit_i[p].valid),
      .flit_i    (flit_i[p]),
      .pop_i     (pop[p]),
      .flit_o    (head[p]),
      .overflow_o(fifo_ovf[p])
    );

    assign route[p] = xy_route(id_i, head[p].dst);
  end

  /////////////////////////////////////////////////////////////////////
  // Arbitration
  /////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        req[o][i] = head[i].valid && (int'(route[i]) == o);
      end
    end
  end

  // Search starts at the input after the last winner
  always_comb begin
    gnt     = '0;
    gnt_idx = '0;
    found   = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int k = 0; k < NumPorts; k++) begin
        if (!found[o] && req[o][rr_index(rr_q[o], k)]) begin
          gnt[o][rr_index(rr_q[o], k)] = 1'b1;
          gnt_idx[o]                   = rr_index(rr_q[o], k);
          found[o]                     = 1'b1;
        end
      end
    end
  end

  // Each head requests one output, so at most one grant per input
  always_comb begin
    pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      pop = pop | gnt[o];
    end
  end

  /////////////////////////////////////////////////////////////////////
  // Output registers
  /////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= '0;
      rr_q        <= '0;
    end else begin
      out_valid_q <= found;
      for (int o = 0; o < NumPorts; o++) begin
        if (found[o]) rr_q[o] <= rr_index(gnt_idx[o], 1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (found[o]) out_q[o] <= head[gnt_idx[o]];
    end
  end

  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      flit_o[o]       = out_q[o];
      flit_o[o].valid = out_valid_q[o];
    end
  end

  assign overflow_o = |fifo_ovf;

endmodule

//--- rtl/tile_chimney.sv
//////////////////////////////////////////////////////////////////////
// Network interface: packs core requests into flits, queues them for
// injection and sorts ejected flits into core responses and
// scratchpad requests
//////////////////////////////////////////////////////////////////////

module tile_chimney #(
  parameter int unsigned InFifoDepth = 2
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  noc_pkg::coord_t     id_i,
  input  tile_pkg::core_req_t core_req_i,
  output tile_pkg::core_rsp_t core_rsp_o,
  output noc_pkg::noc_flit_t  inject_flit_o,
  input  noc_pkg::noc_flit_t  eject_flit_i,
  output noc_pkg::noc_flit_t  spm_req_o,
  input  noc_pkg::noc_flit_t  spm_rsp_i,
  output logic                overflow_o
);
  import noc_pkg::*;
  import tile_pkg::*;

  tag_t      tag_q;
  noc_flit_t core_flit, queue_head;
  logic      queue_pop;

  /////////////////////////////////////////////////////////////////////
  // Request path
  /////////////////////////////////////////////////////////////////////

  always_comb begin
    core_flit.valid = core_req_i.valid;
    core_flit.dst   = coord_t'(core_req_i.dst);
    core_flit.src   = id_i;
    core_flit.kind  = core_req_i.write ? KindWrite : KindRead;
    core_flit.tag   = tag_q;
    core_flit.addr  = core_req_i.addr;
    core_flit.data  = core_req_i.wdata;
  end

  // One tag per accepted request, wraps at 16
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tag_q <= '0;
    end else if (core_req_i.valid) begin
      tag_q <= tag_q + 1'b1;
    end
  end

  noc_in_fifo #(
    .Depth(InFifoDepth)
  ) i_inject_queue (
    .clk_i,
    .arst_n_i,
    .push_i    (core_req_i.valid),
    .flit_i    (core_flit),
    .pop_i     (queue_pop),
    .flit_o    (queue_head),
    .overflow_o(overflow_o)
  );

  // Scratchpad responses go first, the queue waits a cycle
  assign queue_pop     = queue_head.valid && !spm_rsp_i.valid;
  assign inject_flit_o = spm_rsp_i.valid ? spm_rsp_i : queue_head;

  /////////////////////////////////////////////////////////////////////
  // Eject path
  /////////////////////////////////////////////////////////////////////

  always_comb begin
    core_rsp_o.valid = eject_flit_i.valid && (eject_flit_i.kind == KindRsp);
    core_rsp_o.tag   = core_tag_t'(eject_flit_i.tag);
    core_rsp_o.src   = core_coord_t'(eject_flit_i.src);
    core_rsp_o.rdata = eject_flit_i.data;
  end

  always_comb begin
    spm_req_o       = eject_flit_i;
    spm_req_o.valid = eject_flit_i.valid && (eject_flit_i.kind != KindRsp);
  end

endmodule

//--- rtl/tile_scratchpad.sv
//////////////////////////////////////////////////////////////////////
// Tile scratchpad: word memory serving request flits, answers with a
// registered response flit
//////////////////////////////////////////////////////////////////////

module tile_scratchpad #(
  parameter int unsigned SpmWords = 256
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  noc_pkg::coord_t    id_i,
  input  noc_pkg::noc_flit_t req_flit_i,
  output noc_pkg::noc_flit_t rsp_flit_o
);
  import noc_pkg::*;
  import tile_pkg::*;

  localparam int unsigned IdxW = (SpmWords > 1) ? $clog2(SpmWords) : 1;

  spm_data_t       mem_q [SpmWords];
  logic [IdxW-1:0] idx;
  logic            is_write;
  noc_flit_t       rsp_d, rsp_q;
  logic            rsp_valid_q;

  assign idx      = IdxW'(req_flit_i.addr);
  assign is_write = (req_flit_i.kind == KindWrite);

  // Response goes back to the requester with its tag
  always_comb begin
    rsp_d.valid = req_flit_i.valid;
    rsp_d.dst   = req_flit_i.src;
    rsp_d.src   = id_i;
    rsp_d.kind  = KindRsp;
    rsp_d.tag   = req_flit_i.tag;
    rsp_d.addr  = req_flit_i.addr;
    rsp_d.data  = is_write ? req_flit_i.data : mem_q[idx];
  end

  always_ff @(posedge clk_i) begin
    if (req_flit_i.valid) begin
      if (is_write) mem_q[idx] <= req_flit_i.data;
      rsp_q <= rsp_d;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_flit_i.valid;
    end
  end

  always_comb begin
    rsp_flit_o       = rsp_q;
    rsp_flit_o.valid = rsp_valid_q;
  end

endmodule

//--- rtl/noc_tile.sv
//////////////////////////////////////////////////////////////////////
// Mesh tile top: router, network interface and scratchpad
//////////////////////////////////////////////////////////////////////

module noc_tile #(
  parameter int unsigned InFifoDepth = 2,
  parameter int unsigned SpmWords    = 256
) (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  noc_pkg::coord_t                                id_i,
  input  noc_pkg::noc_flit_t [noc_pkg::West:noc_pkg::North] flit_i,
  output noc_pkg::noc_flit_t [noc_pkg::West:noc_pkg::North] flit_o,
  input  tile_pkg::core_req_t                            core_req_i,
  output tile_pkg::core_rsp_t                            core_rsp_o,
  output logic                                           err_o
);
  import noc_pkg::*;

  noc_flit_t [Eject:North] router_in, router_out;
  noc_flit_t               spm_req, spm_rsp;
  logic                    router_ovf, chimney_ovf;

  /////////////////////////////////////////////////////////////////////
  // Router
  /////////////////////////////////////////////////////////////////////

  assign router_in[West:North] = flit_i;
  assign flit_o                = router_out[West:North];

  noc_router #(
    .InFifoDepth(InFifoDepth)
  ) i_router (
    .clk_i,
    .arst_n_i,
    .id_i,
    .flit_i    (router_in),
    .flit_o    (router_out),
    .overflow_o(router_ovf)
  );

  /////////////////////////////////////////////////////////////////////
  // Chimney and scratchpad
  /////////////////////////////////////////////////////////////////////

  tile_chimney #(
    .InFifoDepth(InFifoDepth)
  ) i_chimney (
    .clk_i,
    .arst_n_i,
    .id_i,
    .core_req_i,
    .core_rsp_o,
    .inject_flit_o(router_in[Eject]),
    .eject_flit_i (router_out[Eject]),
    .spm_req_o    (spm_req),
    .spm_rsp_i    (spm_rsp),
    .overflow_o   (chimney_ovf)
  );

  tile_scratchpad #(
    .SpmWords(SpmWords)
  ) i_spm (
    .clk_i,
    .arst_n_i,
    .id_i,
    .req_flit_i(spm_req),
    .rsp_flit_o(spm_rsp)
  );

  assign err_o = router_ovf | chimney_ovf;

endmodule

//--- tests/noc_tile_asserts.sv
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the tile top: XY port of every outgoing flit,
// idle outputs after reset, sticky error flag
//////////////////////////////////////////////////////////////////////

module noc_tile_asserts (
  input logic                           clk_i,
  input logic                           arst_n_i,
  input noc_pkg::coord_t                id_i,
  input noc_pkg::noc_flit_t [3:0]       flit_o,
  input tile_pkg::core_rsp_t            core_rsp_o,
  input logic                           err_o
);
  import noc_pkg::*;

  int unsigned fail_cnt = 0;

  // X first, then Y
  function automatic dir_e port_for(coord_t own, coord_t dst);
    if (dst.x > own.x) return East;
    if (dst.x < own.x) return West;
    if (dst.y > own.y) return South;
    if (dst.y < own.y) return North;
    return Eject;
  endfunction

  for (genvar p = 0; p < 4; p++) begin : gen_route
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      flit_o[p].valid |-> int'(port_for(id_i, flit_o[p].dst)) == p)
    else begin
      fail_cnt++;
      $error("flit left on port %0d against the XY rule", p);
    end
  end

  assert property (@(posedge clk_i) $rose(arst_n_i) |->
    !(flit_o[0].valid || flit_o[1].valid || flit_o[2].valid || flit_o[3].valid)
    && !core_rsp_o.valid && !err_o)
  else begin
    fail_cnt++;
    $error("outputs not idle right after reset");
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) err_o |=> err_o)
  else begin
    fail_cnt++;
    $error("err_o fell without a reset");
  end

endmodule

bind noc_tile noc_tile_asserts i_asserts (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .id_i      (id_i),
  .flit_o    (flit_o),
  .core_rsp_o(core_rsp_o),
  .err_o     (err_o)
);

//--- tests/tb_noc_tile.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the mesh tile: neighbour and core stimulus, expected
// flit and response queues, scratchpad model, closing report
//////////////////////////////////////////////////////////////////////

module tb_noc_tile;
  import noc_pkg::*;
  import tile_pkg::*;

  localparam int unsigned MaxCycles = 4000;
  localparam coord_t      OwnId     = '{x: 2'd1, y: 2'd1};

  typedef struct packed {
    logic [1:0] port;
    noc_flit_t  flit;
  } exp_flit_t;

  logic            clk;
  logic            arst_n;
  noc_flit_t [3:0] mesh_in;
  noc_flit_t [3:0] mesh_out;
  core_req_t       core_req;
  core_rsp_t       core_rsp;
  logic            err;

  exp_flit_t   exp_flits [$];
  core_rsp_t   exp_rsps [$];
  spm_data_t   spm_model [256];
  tag_t        next_tag;
  logic [15:0] lfsr_q = 16'd61825;
  logic        check_on;
  int unsigned err_cnt;
  int unsigned cycle_cnt;

  noc_tile #(
    .InFifoDepth(2),
    .SpmWords   (256)
  ) i_dut (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .id_i      (OwnId),
    .flit_i    (mesh_in),
    .flit_o    (mesh_out),
    .core_req_i(core_req),
    .core_rsp_o(core_rsp),
    .err_o     (err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt == MaxCycles) begin
      $display("Timeout: the test did not finish within %0d cycles", MaxCycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic dir_e xy_port(coord_t dst);
    if (dst.x > OwnId.x) return East;
    if (dst.x < OwnId.x) return West;
    if (dst.y > OwnId.y) return South;
    if (dst.y < OwnId.y) return North;
    return Eject;
  endfunction

  function automatic coord_t random_away();
    coord_t c;
    do begin
      c = coord_t'(rand_bits(4));
    end while (c == OwnId);
    return c;
  endfunction

  function automatic noc_flit_t make_flit(coord_t dst, coord_t src, flit_kind_e kind,
                                          tag_t tag, spm_addr_t addr, spm_data_t data);
    noc_flit_t f;
    f.valid = 1'b1;
    f.dst   = dst;
    f.src   = src;
    f.kind  = kind;
    f.tag   = tag;
    f.addr  = addr;
    f.data  = data;
    return f;
  endfunction

  function automatic core_rsp_t make_rsp(tag_t tag, coord_t src, spm_data_t data);
    core_rsp_t r;
    r.valid = 1'b1;
    r.tag   = tag;
    r.src   = src;
    r.rdata = data;
    return r;
  endfunction

  // Address is don't-care on responses, data on read requests
  function automatic bit flit_matches(noc_flit_t e, noc_flit_t g);
    if (e.dst != g.dst || e.src != g.src || e.kind != g.kind || e.tag != g.tag) return 0;
    if (e.kind != KindRsp && e.addr != g.addr) return 0;
    if (e.kind != KindRead && e.data != g.data) return 0;
    return 1;
  endfunction

  task automatic expect_flit(dir_e port, noc_flit_t f);
    exp_flits.push_back(exp_flit_t'{port: 2'(port), flit: f});
  endtask

  task automatic expect_rsp(core_rsp_t r);
    exp_rsps.push_back(r);
  endtask

  task automatic next_cycle();
    @(negedge clk);
    mesh_in  = '0;
    core_req = '0;
  endtask

  task automatic wait_drain();
    while (exp_flits.size() != 0 || exp_rsps.size() != 0) next_cycle();
    repeat (2) next_cycle();
  endtask

  task automatic apply_reset();
    arst_n   = 1'b0;
    mesh_in  = '0;
    core_req = '0;
    next_tag = '0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
  endtask

  task automatic core_send(input logic write, input coord_t dst, input spm_addr_t addr,
                           input spm_data_t wdata, output tag_t tag);
    core_req.valid = 1'b1;
    core_req.write = write;
    core_req.dst   = dst;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    tag            = next_tag;
    next_tag       = next_tag + 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output checker
  //////////////////////////////////////////////////////////////////////

  task automatic match_flit(int unsigned port, noc_flit_t got);
    int idx;
    idx = -1;
    foreach (exp_flits[i]) begin
      if (idx < 0 && exp_flits[i].port == port && flit_matches(exp_flits[i].flit, got))
        idx = i;
    end
    if (idx < 0) begin
      err_cnt++;
      $display("ERR %0t: unexpected flit on port %0d: %h", $time, port, got);
    end else begin
      exp_flits.delete(idx);
    end
  endtask

  task automatic match_rsp(core_rsp_t got);
    int idx;
    idx = -1;
    foreach (exp_rsps[i]) begin
      if (idx < 0 && exp_rsps[i].tag == got.tag && exp_rsps[i].src == got.src &&
          exp_rsps[i].rdata == got.rdata)
        idx = i;
    end
    if (idx < 0) begin
      err_cnt++;
      $display("ERR %0t: unexpected core response tag %0d data %h", $time, got.tag, got.rdata);
    end else begin
      exp_rsps.delete(idx);
    end
  endtask

  always @(negedge clk) begin
    if (arst_n && check_on) begin
      for (int p = 0; p < 4; p++) begin
        if (mesh_out[p].valid) match_flit(p, mesh_out[p]);
      end
      if (core_rsp.valid) match_rsp(core_rsp);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////////////////////////

  task automatic run_through_traffic();
    noc_flit_t f;
    for (int r = 0; r < 16; r++) begin
      next_cycle();
      for (int p = 0; p < 4; p++) begin
        f = make_flit(random_away(), random_away(), KindWrite, tag_t'(rand_bits(4)),
                      spm_addr_t'(rand_bits(8)), rand_bits(32));
        mesh_in[p] = f;
        expect_flit(xy_port(f.dst), f);
      end
      wait_drain();
    end
  endtask

  task automatic run_local_loopback();
    spm_addr_t addr [6];
    spm_data_t data;
    tag_t      tag;
    for (int i = 0; i < 6; i++) begin
      addr[i] = spm_addr_t'(rand_bits(8));
      data    = rand_bits(32);
      next_cycle();
      core_send(1'b1, OwnId, addr[i], data, tag);
      spm_model[addr[i]] = data;
      expect_rsp(make_rsp(tag, OwnId, data));
      wait_drain();
    end
    for (int i = 0; i < 6; i++) begin
      next_cycle();
      core_send(1'b0, OwnId, addr[i], '0, tag);
      expect_rsp(make_rsp(tag, OwnId, spm_model[addr[i]]));
      wait_drain();
    end
  endtask

  task automatic run_remote_service();
    coord_t    src;
    spm_addr_t addr;
    spm_data_t data;
    tag_t      tag;
    for (int i = 0; i < 8; i++) begin
      src  = random_away();
      addr = spm_addr_t'(rand_bits(8));
      data = rand_bits(32);
      tag  = tag_t'(rand_bits(4));
      next_cycle();
      mesh_in[i % 4] = make_flit(OwnId, src, KindWrite, tag, addr, data);
      spm_model[addr] = data;
      expect_flit(xy_port(src), make_flit(src, OwnId, KindRsp, tag, addr, data));
      wait_drain();
      next_cycle();
      tag = tag + 1'b1;
      mesh_in[(i + 1) % 4] = make_flit(OwnId, src, KindRead, tag, addr, '0);
      expect_flit(xy_port(src), make_flit(src, OwnId, KindRsp, tag, addr, spm_model[addr]));
      wait_drain();
    end
  endtask

  task automatic run_outbound();
    coord_t    dst;
    spm_addr_t addr;
    spm_data_t data;
    tag_t      tag;
    logic      wr;
    for (int i = 0; i < 8; i++) begin
      dst  = random_away();
      addr = spm_addr_t'(rand_bits(8));
      data = rand_bits(32);
      wr   = 1'(rand_bits(1));
      next_cycle();
      core_send(wr, dst, addr, data, tag);
      expect_flit(xy_port(dst),
                  make_flit(dst, OwnId, wr ? KindWrite : KindRead, tag, addr, data));
      wait_drain();
      // Remote tile answers
      data = rand_bits(32);
      next_cycle();
      mesh_in[i % 4] = make_flit(OwnId, dst, KindRsp, tag, addr, data);
      expect_rsp(make_rsp(tag, dst, data));
      wait_drain();
    end
  endtask

  // North, South, West and the core all aim at East
  task automatic run_contention();
    noc_flit_t   f;
    coord_t      dst;
    logic [31:0] r;
    spm_addr_t   addr;
    spm_data_t   data;
    tag_t        tag;
    for (int c = 0; c < 2; c++) begin
      next_cycle();
      for (int p = 0; p < 4; p++) begin
        if (p != int'(East)) begin
          r     = rand_bits(3);
          dst.x = {1'b1, r[0]};
          dst.y = r[2:1];
          f = make_flit(dst, random_away(), KindWrite, tag_t'(rand_bits(4)),
                        spm_addr_t'(rand_bits(8)), rand_bits(32));
          mesh_in[p] = f;
          expect_flit(East, f);
        end
      end
      dst  = '{x: 2'd3, y: 2'(rand_bits(2))};
      addr = spm_addr_t'(rand_bits(8));
      data = rand_bits(32);
      core_send(1'b1, dst, addr, data, tag);
      expect_flit(East, make_flit(dst, OwnId, KindWrite, tag, addr, data));
    end
    wait_drain();
    if (err) begin
      err_cnt++;
      $display("ERR %0t: err_o raised under paced contention", $time);
    end
  endtask

  task automatic run_overflow();
    coord_t far_east;
    far_east = '{x: 2'd3, y: 2'd0};
    check_on = 1'b0;
    for (int c = 0; c < 12; c++) begin
      next_cycle();
      mesh_in[West]  = make_flit(far_east, random_away(), KindWrite, tag_t'(c), '0, '0);
      mesh_in[North] = make_flit(far_east, random_away(), KindWrite, tag_t'(c), '1, '1);
    end
    repeat (10) next_cycle();
    if (!err) begin
      err_cnt++;
      $display("ERR %0t: err_o did not rise on FIFO overflow", $time);
    end
    repeat (20) next_cycle();
    if (!err) begin
      err_cnt++;
      $display("ERR %0t: err_o dropped before reset", $time);
    end
    apply_reset();
    next_cycle();
    if (err) begin
      err_cnt++;
      $display("ERR %0t: err_o still high after reset", $time);
    end
    check_on = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    check_on = 1'b1;
    apply_reset();
    run_through_traffic();
    run_local_loopback();
    run_remote_service();
    run_outbound();
    run_contention();
    run_overflow();
    repeat (3) next_cycle();
    $display("Errors: %0d data, %0d assertion", err_cnt, i_dut.i_asserts.fail_cnt);
    if (err_cnt == 0 && i_dut.i_asserts.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- sources.f
rtl/tile_pkg.sv
rtl/noc_pkg.sv
rtl/noc_in_fifo.sv
rtl/noc_router.sv
rtl/tile_chimney.sv
rtl/tile_scratchpad.sv
rtl/noc_tile.sv
tests/noc_tile_asserts.sv
tests/tb_noc_tile.sv
